// ==== alu_mem_top.f ====
rtl/alu_pkg.sv
rtl/ripple_adder.sv
rtl/nibble_multiplier.sv
rtl/shift_rotate_unit.sv
rtl/alu_core.sv
rtl/word_ram.sv
rtl/alu_mem_top.sv
tests/alu_mem_top_properties.sv
tests/alu_mem_top_tb.sv

// ==== rtl/alu_core.sv ====
// 8-bit combinational ALU
// decodes the opcode, feeds the adder, multiplier and shift network,
// computes the bitwise ops and selects the result

`timescale 1ns/10ps

module alu_core #(
	parameter int DATA_W  = alu_pkg::DATA_W,
	parameter int MULT_W  = alu_pkg::MULT_W,
	parameter int SHAMT_W = alu_pkg::SHAMT_W
) (
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  alu_pkg::alu_op_e  op,
	output logic [DATA_W-1:0] y
);

	import alu_pkg::*;

	// adder operands after inversion
	logic [DATA_W-1:0]   add_a;
	logic [DATA_W-1:0]   add_b;
	logic                add_cin;
	logic [DATA_W-1:0]   add_sum;
	logic [2*MULT_W-1:0] mult_p;
	shift_kind_e         sh_kind;
	logic [DATA_W-1:0]   sh_y;

	//////////////////////////////////////////////////////////////////////
	// operand preparation
	//////////////////////////////////////////////////////////////////////
	// subtraction is a + ~b + 1, reverse subtraction ~a + b + 1
	always_comb begin
		add_a   = a;
		add_b   = b;
		add_cin = 1'b0;
		case (op)
			OP_SUB: begin
				add_b   = ~b;
				add_cin = 1'b1;
			end
			OP_RSB: begin
				add_a   = ~a;
				add_cin = 1'b1;
			end
			default: ;
		endcase
	end

	// shift kind from the opcode, only meaningful for the shift group
	always_comb begin
		case (op)
			OP_SRL:  sh_kind = SK_SRL;
			OP_SLL:  sh_kind = SK_SLL;
			OP_ROR:  sh_kind = SK_ROR;
			default: sh_kind = SK_ROL;
		endcase
	end

	// carry out is dropped, results wrap modulo 2**DATA_W
	ripple_adder #(.WIDTH(DATA_W)) u_adder (
		.a(add_a), .b(add_b), .cin(add_cin), .sum(add_sum), .cout()
	);

	// product of the upper halves, low halves ignored
	nibble_multiplier #(.WIDTH(MULT_W)) u_mult (
		.a(a[DATA_W-1 -: MULT_W]), .b(b[DATA_W-1 -: MULT_W]), .product(mult_p)
	);

	shift_rotate_unit #(.WIDTH(DATA_W), .SHAMT_W(SHAMT_W)) u_shift (
		.a(a), .amount(b[SHAMT_W-1:0]), .kind(sh_kind), .y(sh_y)
	);

	//////////////////////////////////////////////////////////////////////
	// result select
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (op)
			OP_ADD, OP_SUB, OP_RSB:         y = add_sum;
			OP_MULH:                        y = DATA_W'(mult_p);
			OP_NOR:                         y = ~(a | b);
			// only b is inverted
			OP_NOTB:                        y = ~b;
			OP_NAND:                        y = ~(a & b);
			OP_XNOR:                        y = a ~^ b;
			OP_SRL, OP_SLL, OP_ROR, OP_ROL: y = sh_y;
			// the four no-op codes
			default:                        y = '0;
		endcase
	end

endmodule

// ==== rtl/alu_mem_top.sv ====
// top level of the ALU and RAM block
// the combinational ALU and the word RAM sit side by side with their own ports

`timescale 1ns/10ps

module alu_mem_top #(
	parameter int DATA_W     = alu_pkg::DATA_W,
	parameter int MULT_W     = alu_pkg::MULT_W,
	parameter int SHAMT_W    = alu_pkg::SHAMT_W,
	parameter int RAM_DEPTH  = alu_pkg::RAM_DEPTH,
	parameter int RAM_ADDR_W = alu_pkg::RAM_ADDR_W
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [DATA_W-1:0]     alu_a,
	input  logic [DATA_W-1:0]     alu_b,
	input  alu_pkg::alu_op_e      alu_op,
	output logic [DATA_W-1:0]     alu_y,
	input  logic                  ram_en,
	input  logic                  ram_we,
	input  logic                  ram_re,
	input  logic [RAM_ADDR_W-1:0] ram_addr,
	input  logic [DATA_W-1:0]     ram_wr_data,
	output logic [DATA_W-1:0]     ram_rd_data
);

	// ALU path, no clock
	alu_core #(.DATA_W(DATA_W), .MULT_W(MULT_W), .SHAMT_W(SHAMT_W)) u_alu_core (
		.a(alu_a), .b(alu_b), .op(alu_op), .y(alu_y)
	);

	// RAM words are as wide as the ALU data
	word_ram #(.WORD_W(DATA_W), .DEPTH(RAM_DEPTH), .ADDR_W(RAM_ADDR_W)) u_word_ram (
		.clk(clk), .rst(rst), .en(ram_en), .we(ram_we), .re(ram_re),
		.addr(ram_addr), .wr_data(ram_wr_data), .rd_data(ram_rd_data)
	);

endmodule

// ==== rtl/alu_pkg.sv ====
// shared definitions for the ALU and RAM block
// operand widths, RAM geometry, ALU opcodes and shift kinds

package alu_pkg;

	// datapath widths
	parameter int DATA_W  = 8;
	// each multiplier operand is the upper half of a word
	parameter int MULT_W  = DATA_W / 2;
	parameter int SHAMT_W = $clog2(DATA_W);

	// RAM geometry
	parameter int RAM_DEPTH  = 512;
	parameter int RAM_ADDR_W = $clog2(RAM_DEPTH);

	//////////////////////////////////////////////////////////////////////
	// ALU opcodes, 12 live and 4 no-ops
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		OP_NOP0 = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_RSB  = 4'd3,
		OP_MULH = 4'd4,
		OP_NOP5 = 4'd5,
		OP_NOP6 = 4'd6,
		OP_NOP7 = 4'd7,
		OP_NOR  = 4'd8,
		OP_NOTB = 4'd9,
		OP_NAND = 4'd10,
		OP_XNOR = 4'd11,
		OP_SRL  = 4'd12,
		OP_SLL  = 4'd13,
		OP_ROR  = 4'd14,
		OP_ROL  = 4'd15
	} alu_op_e;

	// shift network selection, follows the low two opcode bits of the shift group
	typedef enum logic [1:0] {
		SK_SRL = 2'd0,
		SK_SLL = 2'd1,
		SK_ROR = 2'd2,
		SK_ROL = 2'd3
	} shift_kind_e;

endpackage

// ==== rtl/nibble_multiplier.sv ====
// layered unsigned array multiplier
// one layer per bit of b, each layer retires one product bit

`timescale 1ns/10ps

module nibble_multiplier #(
	parameter int WIDTH = alu_pkg::MULT_W
) (
	input  logic [WIDTH-1:0]   a,
	input  logic [WIDTH-1:0]   b,
	output logic [2*WIDTH-1:0] product
);

	// upper partial sum handed from each layer to the next
	logic [WIDTH-1:0] part [WIDTH];

	//////////////////////////////////////////////////////////////////////
	// multiplier layers
	//////////////////////////////////////////////////////////////////////
	genvar i;
	generate
		for (i = 0; i < WIDTH; i++) begin : g_layer
			// scalar product of a with one bit of b
			logic [WIDTH-1:0] tt;

			assign tt = a & {WIDTH{b[i]}};

			if (i == 0) begin : g_first
				// nothing to add yet, the layer only splits off bit 0
				assign product[0] = tt[0];
				assign part[0]    = {1'b0, tt[WIDTH-1:1]};
			end else begin : g_rest
				// sum is one bit wider to keep the carry
				logic [WIDTH:0] layer_sum;

				assign layer_sum  = {1'b0, tt} + {1'b0, part[i-1]};
				// lsb is finished, the rest moves down one weight
				assign product[i] = layer_sum[0];
				assign part[i]    = layer_sum[WIDTH:1];
			end
		end
	endgenerate

	// final layer holds the upper product bits
	assign product[2*WIDTH-1:WIDTH] = part[WIDTH-1];

endmodule

// ==== rtl/ripple_adder.sv ====
// ripple-carry adder
// chain of full-adder cells, carry enters at bit zero and leaves at the top

`timescale 1ns/10ps

module ripple_adder #(
	parameter int WIDTH = alu_pkg::DATA_W
) (
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic             cin,
	output logic [WIDTH-1:0] sum,
	output logic             cout
);

	// carry into each bit, carry[WIDTH] is the final carry out
	logic [WIDTH:0] carry;

	assign carry[0] = cin;

	//////////////////////////////////////////////////////////////////////
	// full-adder cells
	//////////////////////////////////////////////////////////////////////
	genvar i;
	generate
		for (i = 0; i < WIDTH; i++) begin : g_cell
			// half-sum of the two operand bits
			logic hs;

			assign hs = a[i] ^ b[i];
			assign sum[i] = hs ^ carry[i];
			// generate, or propagate an incoming carry
			assign carry[i+1] = (a[i] & b[i]) | (carry[i] & hs);
		end
	endgenerate

	assign cout = carry[WIDTH];

endmodule

// ==== rtl/shift_rotate_unit.sv ====
// shift and rotate network
// builds every shifted and rotated copy of a, then picks one by amount and kind

`timescale 1ns/10ps

module shift_rotate_unit #(
	parameter int WIDTH   = alu_pkg::DATA_W,
	parameter int SHAMT_W = alu_pkg::SHAMT_W
) (
	input  logic [WIDTH-1:0]   a,
	input  logic [SHAMT_W-1:0] amount,
	input  alu_pkg::shift_kind_e kind,
	output logic [WIDTH-1:0]   y
);

	import alu_pkg::*;

	localparam int NUM_AMT = 2 ** SHAMT_W;

	// one copy per possible amount
	logic [WIDTH-1:0] srl_v [NUM_AMT];
	logic [WIDTH-1:0] sll_v [NUM_AMT];
	logic [WIDTH-1:0] ror_v [NUM_AMT];
	logic [WIDTH-1:0] rol_v [NUM_AMT];

	//////////////////////////////////////////////////////////////////////
	// candidate copies, fixed wiring per amount
	//////////////////////////////////////////////////////////////////////
	genvar k;
	generate
		for (k = 0; k < NUM_AMT; k++) begin : g_amt
			// shifts fill with zeros
			assign srl_v[k] = a >> k;
			assign sll_v[k] = a << k;
			// rotates wrap, at k = 0 the wrapped part is empty
			assign ror_v[k] = (a >> k) | (a << (WIDTH - k));
			assign rol_v[k] = (a << k) | (a >> (WIDTH - k));
		end
	endgenerate

	// output select
	always_comb begin
		case (kind)
			SK_SRL:  y = srl_v[amount];
			SK_SLL:  y = sll_v[amount];
			SK_ROR:  y = ror_v[amount];
			default: y = rol_v[amount];
		endcase
	end

endmodule

// ==== rtl/word_ram.sv ====
// synchronous single-port RAM
// writes or reads only when enabled with exactly one strobe high,
// read data is registered

`timescale 1ns/10ps

module word_ram #(
	parameter int WORD_W = alu_pkg::DATA_W,
	parameter int DEPTH  = alu_pkg::RAM_DEPTH,
	parameter int ADDR_W = alu_pkg::RAM_ADDR_W
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              en,
	input  logic              we,
	input  logic              re,
	input  logic [ADDR_W-1:0] addr,
	input  logic [WORD_W-1:0] wr_data,
	output logic [WORD_W-1:0] rd_data
);

	logic [WORD_W-1:0] mem [DEPTH];

	// qualified strobes, both high counts as neither
	logic wr_ok;
	logic rd_ok;

	assign wr_ok = en & we & ~re;
	assign rd_ok = en & re & ~we;

	// storage array
	always_ff @(posedge clk) begin
		if (wr_ok)
			mem[addr] <= wr_data;
	end

	// read port, holds its value unless a qualified read occurs
	always_ff @(posedge clk) begin
		if (rst)
			rd_data <= '0;
		else if (rd_ok)
			rd_data <= mem[addr];
	end

endmodule

// ==== tests/alu_mem_top_golden.txt ====
# columns: test name, kind (alu wr rd idle), three fields, expected value, all hex
# alu: a b op | wr and rd: address data {en,we,re} | idle: unused fields
rst_rd       idle 000 00 0 00
add_wrap     alu  0c8 64 1 2c
add_small    alu  00c 22 1 2e
sub_wrap     alu  003 05 2 fe
sub_basic    alu  050 20 2 30
rsb_basic    alu  010 30 3 20
rsb_wrap     alu  005 03 3 fe
mulh_max     alu  0f0 f0 4 e1
mulh_low_ign alu  0ff ff 4 e1
mulh_mixed   alu  03a 57 4 0f
nor_op       alu  00f 33 8 c0
notb_op      alu  0ff 5a 9 a5
nand_op      alu  0f0 3c a cf
xnor_op      alu  0a5 0f b 55
nop0_zero    alu  0ff ff 0 00
nop5_zero    alu  012 34 5 00
nop6_zero    alu  0aa 55 6 00
nop7_zero    alu  0ff 01 7 00
srl_3        alu  0b4 03 c 16
srl_hi_ign   alu  0b4 fb c 16
sll_2        alu  0b4 02 d d0
ror_1        alu  081 01 e c0
rol_1        alu  081 01 f 03
rol_3        alu  096 03 f b4
srl_zero     alu  05c 08 c 5c
rol_zero     alu  05c 00 f 5c
wr_first     wr   000 a5 6 00
wr_last      wr   1ff 3c 6 00
wr_mid       wr   0a5 5a 6 00
rd_first     rd   000 00 5 a5
rd_last      rd   1ff 00 5 3c
rd_mid       rd   0a5 00 5 5a
wr_en_low    wr   000 77 2 00
wr_both      wr   000 88 7 00
rd_blocked   rd   000 00 5 a5
rd_en_low    rd   1ff 00 1 a5
rd_both      rd   1ff 00 7 a5
hold_idle    idle 000 00 0 a5
rd_last_2    rd   1ff 00 5 3c

// ==== tests/alu_mem_top_properties.sv ====
// port-level assertions for the ALU and RAM block
// read data reset and hold rules and the zero result of the no-op codes

`timescale 1ns/10ps

module alu_mem_top_properties #(
	parameter int DATA_W = alu_pkg::DATA_W
) (
	input  logic              clk,
	input  logic              rst,
	input  alu_pkg::alu_op_e  alu_op,
	input  logic [DATA_W-1:0] alu_y,
	input  logic              ram_en,
	input  logic              ram_we,
	input  logic              ram_re,
	input  logic [DATA_W-1:0] ram_rd_data
);

	import alu_pkg::*;

	// a read counts only when enabled with the read strobe alone
	logic rd_ok;
	logic no_op;
	// count of failed assertions
	int   fail_hits;

	initial fail_hits = 0;

	assign rd_ok = ram_en & ram_re & ~ram_we;
	assign no_op = alu_op inside {OP_NOP0, OP_NOP5, OP_NOP6, OP_NOP7};

	a_reset_clears: assert property (@(posedge clk) rst |=> ram_rd_data == '0)
		else begin
			$error("read data is not zero in the cycle after reset");
			fail_hits++;
		end

	// without a qualified read the output register keeps its word
	a_read_hold: assert property (@(posedge clk) (!rst && !rd_ok) |=> $stable(ram_rd_data))
		else begin
			$error("read data changed without a qualified read");
			fail_hits++;
		end

	a_nop_zero: assert property (@(posedge clk) no_op |-> alu_y == '0)
		else begin
			$error("ALU result is not zero for a no-op code");
			fail_hits++;
		end

endmodule

bind alu_mem_top alu_mem_top_properties #(.DATA_W(DATA_W)) u_properties (
	.clk(clk), .rst(rst), .alu_op(alu_op), .alu_y(alu_y),
	.ram_en(ram_en), .ram_we(ram_we), .ram_re(ram_re), .ram_rd_data(ram_rd_data)
);

// ==== tests/alu_mem_top_tb.sv ====
// testbench for the ALU and RAM block
// replays the golden vectors, then random ALU vectors against a reference model

`timescale 1ns/10ps

module alu_mem_top_tb;

	import alu_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int NUM_RANDOM   = 200;
	localparam int SLACK_CYCLES = 20;

	logic                  clk;
	logic                  rst;
	logic [DATA_W-1:0]     alu_a;
	logic [DATA_W-1:0]     alu_b;
	alu_op_e               alu_op;
	logic [DATA_W-1:0]     alu_y;
	logic                  ram_en;
	logic                  ram_we;
	logic                  ram_re;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic [DATA_W-1:0]     ram_wr_data;
	logic [DATA_W-1:0]     ram_rd_data;

	// golden vectors with one entry per test line
	string       name_q [$];
	string       kind_q [$];
	logic [15:0] x_q [$];
	logic [15:0] y_q [$];
	logic [15:0] z_q [$];
	logic [7:0]  exp_q [$];
	int          pass_count;
	int          fail_count;
	int          prop_fails;
	bit          loaded;
	bit          opened;

	alu_mem_top u_alu_mem_top (
		.clk(clk), .rst(rst), .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_y(alu_y),
		.ram_en(ram_en), .ram_we(ram_we), .ram_re(ram_re), .ram_addr(ram_addr),
		.ram_wr_data(ram_wr_data), .ram_rd_data(ram_rd_data)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// reference model following the opcode table
	//////////////////////////////////////////////////////////////////////
	function automatic logic [DATA_W-1:0] model_alu(input logic [DATA_W-1:0] a,
			input logic [DATA_W-1:0] b, input alu_op_e op);
		logic [2*DATA_W-1:0] twice;
		int                  amt;
		logic [DATA_W-1:0]   r;

		twice = {a, a};
		amt   = b % DATA_W;
		case (op)
			OP_ADD:  r = a + b;
			OP_SUB:  r = a - b;
			OP_RSB:  r = b - a;
			OP_MULH: r = a[DATA_W-1 -: MULT_W] * b[DATA_W-1 -: MULT_W];
			OP_NOR:  r = ~(a | b);
			OP_NOTB: r = ~b;
			OP_NAND: r = ~(a & b);
			OP_XNOR: r = ~(a ^ b);
			OP_SRL:  r = a >> amt;
			OP_SLL:  r = a << amt;
			// rotates read a window out of the doubled word
			OP_ROR:  r = twice >> amt;
			OP_ROL:  r = (twice << amt) >> DATA_W;
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic check_value(input string name, input logic [7:0] expected,
			input logic [7:0] actual, input bit quiet);
		assert (actual === expected) begin
			pass_count++;
			if (!quiet)
				$display("done %s ok", name);
		end else begin
			fail_count++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic load_golden(output bit ok);
		int                fd;
		int                n;
		logic [8*120-1:0]  line_buf;
		logic [8*24-1:0]   name_buf;
		logic [8*8-1:0]    kind_buf;
		logic [15:0]       x;
		logic [15:0]       y;
		logic [15:0]       z;
		logic [7:0]        e;

		fd = $fopen("tests/alu_mem_top_golden.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			line_buf = '0;
			while ($fgets(line_buf, fd) != 0) begin
				name_buf = '0;
				kind_buf = '0;
				n = $sscanf(line_buf, "%s %s %h %h %h %h", name_buf, kind_buf, x, y, z, e);
				// comment and blank lines carry fewer fields
				if (n == 6) begin
					name_q.push_back(string'(name_buf));
					kind_q.push_back(string'(kind_buf));
					x_q.push_back(x);
					y_q.push_back(y);
					z_q.push_back(z);
					exp_q.push_back(e);
				end
				line_buf = '0;
			end
			$fclose(fd);
		end
	endtask

	// starts on a falling edge and returns on the next one
	task automatic apply_line(input int i);
		string kind;

		kind   = kind_q[i];
		ram_en = 1'b0;
		ram_we = 1'b0;
		ram_re = 1'b0;
		if (kind == "alu") begin
			alu_a  = x_q[i][DATA_W-1:0];
			alu_b  = y_q[i][DATA_W-1:0];
			alu_op = alu_op_e'(z_q[i][3:0]);
		end else if (kind == "wr" || kind == "rd") begin
			ram_addr    = x_q[i][RAM_ADDR_W-1:0];
			ram_wr_data = y_q[i][DATA_W-1:0];
			{ram_en, ram_we, ram_re} = z_q[i][2:0];
		end
		// just before the rising edge
		#(CLK_PERIOD/2 - 10);
		if (kind == "alu")
			check_value(name_q[i], exp_q[i], alu_y, 1'b0);
		else if (kind == "idle")
			check_value(name_q[i], exp_q[i], ram_rd_data, 1'b0);
		@(posedge clk);
		@(negedge clk);
		// read data lands after the sampling edge
		if (kind == "rd") begin
			check_value(name_q[i], exp_q[i], ram_rd_data, 1'b0);
		end else if (kind == "wr") begin
			$display("done %s written", name_q[i]);
		end else if (kind != "alu" && kind != "idle") begin
			fail_count++;
			$display("golden line %s has an unknown kind %s", name_q[i], kind);
		end
	endtask

	task automatic run_random();
		alu_op_e op;

		for (int k = 0; k < NUM_RANDOM; k++) begin
			alu_a  = $urandom;
			alu_b  = $urandom;
			op     = alu_op_e'(4'($urandom));
			alu_op = op;
			#(CLK_PERIOD/2 - 10);
			check_value($sformatf("random_alu[%0d]", k), model_alu(alu_a, alu_b, op),
				alu_y, 1'b1);
			@(posedge clk);
			@(negedge clk);
		end
		$display("done random_alu, %0d vectors", NUM_RANDOM);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		alu_a       = '0;
		alu_b       = '0;
		alu_op      = OP_NOP0;
		ram_en      = 1'b0;
		ram_we      = 1'b0;
		ram_re      = 1'b0;
		ram_addr    = '0;
		ram_wr_data = '0;
		pass_count  = 0;
		fail_count  = 0;
		prop_fails  = 0;
		loaded      = 1'b0;
		void'($urandom(32'hc00c40bd));
		load_golden(opened);
		if (!opened) begin
			$display("could not open the golden file tests/alu_mem_top_golden.txt");
			$display("Test failed");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (2) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			foreach (name_q[i])
				apply_line(i);
			run_random();
			// bound assertion failures count against the run
			prop_fails = u_alu_mem_top.u_properties.fail_hits;
			if (prop_fails != 0) begin
				$display("%0d bound property assertions failed", prop_fails);
				fail_count += prop_fails;
			end
			$display("summary: %0d checks passed, %0d failed", pass_count, fail_count);
			if (fail_count == 0)
				$display("Test passed");
			else
				$display("Test failed");
			$finish;
		end
	end

	// watchdog allows one cycle per golden line and random vector plus slack
	initial begin
		wait (loaded);
		#((name_q.size() + NUM_RANDOM + SLACK_CYCLES) * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

endmodule
